/* include/relay_macros.svh */
`ifndef RELAY_MACROS_SVH
`define RELAY_MACROS_SVH

// one destination queue per ToR
`define RELAY_QUEUE_NUM      8

// ToRs on each OCS
`define RELAY_TOR_NUM        8

// slots in one OCS cycle
`define RELAY_SLOT_NUM       2

// byte counts
`define RELAY_SIZE_W         32

// buffer budget per queue for one slot
`define RELAY_SLOT_MAX_BYTES 32'h0004_0000

`endif

/* hw/relay_pkg.sv */
`include "relay_macros.svh"

package relay_pkg;

    // byte count
    typedef logic [`RELAY_SIZE_W-1:0] size_t;

    // node index on an OCS
    typedef logic [$clog2(`RELAY_TOR_NUM)-1:0] tor_id_t;

    // slot index within the OCS cycle
    typedef logic [$clog2(`RELAY_SLOT_NUM)-1:0] slot_id_t;

    // one byte count per destination queue
    // entry q sits at bits [q*RELAY_SIZE_W +: RELAY_SIZE_W]
    typedef size_t [`RELAY_QUEUE_NUM-1:0] size_vec_t;

endpackage

/* hw/slot_snapshot.sv */
`timescale 1ns/1ns

module slot_snapshot (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_slot_start,
    input  relay_pkg::slot_id_t  i_slot_id,
    input  logic                 i_queue_ack,
    input  relay_pkg::size_vec_t i_local_size,
    input  relay_pkg::size_vec_t i_unlocal_size,
    output logic                 o_queue_req,
    output logic                 o_snap_valid,
    output relay_pkg::slot_id_t  o_snap_slot_id,
    output relay_pkg::size_vec_t o_snap_local,
    output relay_pkg::size_vec_t o_snap_unlocal
);

    import relay_pkg::*;

    slot_id_t slot_id_q;
    logic     start_pend;
    logic     launch;
    logic     ack_meta;
    logic     ack_sync;
    logic     ack_sync_d;
    logic     ack_rise;

    ////////////////////////////////////////////////////////////////////////////
    // ack from the queue manager domain
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            ack_meta   <= 1'b0;
            ack_sync   <= 1'b0;
            ack_sync_d <= 1'b0;
        end else begin
            ack_meta   <= i_queue_ack;
            ack_sync   <= ack_meta;
            ack_sync_d <= ack_sync;
        end
    end

    assign ack_rise = ack_sync & ~ack_sync_d;

    // old ack must be gone before the next request
    assign launch = start_pend & ~ack_sync & ~o_queue_req;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            start_pend   <= 1'b0;
            o_queue_req  <= 1'b0;
            o_snap_valid <= 1'b0;
        end else begin
            if (i_slot_start) begin
                start_pend <= 1'b1;
            end else if (launch) begin
                start_pend <= 1'b0;
            end
            if (ack_rise) begin
                o_queue_req <= 1'b0;
            end else if (launch) begin
                o_queue_req <= 1'b1;
            end
            o_snap_valid <= ack_rise;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_slot_start) begin
            slot_id_q <= i_slot_id;
        end
        // sizes are stable while the ack is up
        if (ack_rise) begin
            o_snap_slot_id <= slot_id_q;
            o_snap_local   <= i_local_size;
            o_snap_unlocal <= i_unlocal_size;
        end
    end

endmodule

/* hw/next_hop_lookup.sv */
`timescale 1ns/1ns

`include "relay_macros.svh"

module next_hop_lookup #(
    parameter relay_pkg::tor_id_t my_tor_id = '0
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_snap_valid,
    input  relay_pkg::slot_id_t i_snap_slot_id,
    output logic                o_hop_valid,
    output relay_pkg::tor_id_t  o_hop_ocs0,
    output relay_pkg::tor_id_t  o_hop_ocs1
);

    import relay_pkg::*;

    tor_id_t  even_route [`RELAY_SLOT_NUM];
    tor_id_t  odd_route  [`RELAY_SLOT_NUM];
    slot_id_t next_slot;

    // this node's row of the round-robin tables
    // ocs0 steps forward by 1+2s, ocs1 steps back by the same amount
    for (genvar s = 0; s < `RELAY_SLOT_NUM; s++) begin : g_route
        assign even_route[s] = tor_id_t'((int'(my_tor_id) + 1 + 2 * s) % `RELAY_TOR_NUM);
        assign odd_route[s]  = tor_id_t'((int'(my_tor_id) + 2 * `RELAY_TOR_NUM - 1 - 2 * s)
                                         % `RELAY_TOR_NUM);
    end

    assign next_slot = (i_snap_slot_id == slot_id_t'(`RELAY_SLOT_NUM - 1)) ?
                       '0 : i_snap_slot_id + 1'b1;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_hop_valid <= 1'b0;
            o_hop_ocs0  <= '0;
            o_hop_ocs1  <= '0;
        end else begin
            o_hop_valid <= i_snap_valid;
            if (i_snap_valid) begin
                o_hop_ocs0 <= even_route[next_slot];
                o_hop_ocs1 <= odd_route[next_slot];
            end
        end
    end

endmodule

/* hw/offer_arbiter.sv */
`timescale 1ns/1ns

module offer_arbiter (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_offer_valid_0,
    input  logic                 i_offer_valid_1,
    input  relay_pkg::size_vec_t i_offer_0,
    input  relay_pkg::size_vec_t i_offer_1,
    input  relay_pkg::size_t     i_offer_cap_0,
    input  relay_pkg::size_t     i_offer_cap_1,
    input  logic                 i_alloc_done,
    output logic                 o_grant_valid,
    output logic                 o_grant_port,
    output relay_pkg::size_vec_t o_grant_offer,
    output relay_pkg::size_t     o_grant_cap
);

    import relay_pkg::*;

    logic [1:0] offer_valid;
    size_vec_t  offer_in [2];
    size_t      cap_in   [2];
    size_vec_t  offer_q  [2];
    size_t      cap_q    [2];
    logic [1:0] pend;
    logic [1:0] grant;
    logic       wait_alloc;
    logic       can_grant;

    assign offer_valid = {i_offer_valid_1, i_offer_valid_0};
    assign offer_in[0] = i_offer_0;
    assign offer_in[1] = i_offer_1;
    assign cap_in[0]   = i_offer_cap_0;
    assign cap_in[1]   = i_offer_cap_1;

    // allocator result frees the slot in the same cycle
    assign can_grant = ~wait_alloc | i_alloc_done;

    // port 0 first on a tie
    assign grant[0] = can_grant & pend[0];
    assign grant[1] = can_grant & pend[1] & ~pend[0];

    always_ff @(posedge i_clk) begin
        for (int p = 0; p < 2; p++) begin
            if (offer_valid[p]) begin
                offer_q[p] <= offer_in[p];
                cap_q[p]   <= cap_in[p];
            end
        end
        if (|grant) begin
            o_grant_offer <= offer_q[grant[1]];
            o_grant_cap   <= cap_q[grant[1]];
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            pend          <= '0;
            wait_alloc    <= 1'b0;
            o_grant_valid <= 1'b0;
            o_grant_port  <= 1'b0;
        end else begin
            pend          <= offer_valid | (pend & ~grant);
            o_grant_valid <= |grant;
            if (|grant) begin
                wait_alloc   <= 1'b1;
                o_grant_port <= grant[1];
            end else if (i_alloc_done) begin
                wait_alloc <= 1'b0;
            end
        end
    end

endmodule

/* hw/relay_allocator.sv */
`timescale 1ns/1ns

`include "relay_macros.svh"

module relay_allocator (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_snap_valid,
    input  relay_pkg::size_vec_t i_snap_local,
    input  relay_pkg::size_vec_t i_snap_unlocal,
    input  relay_pkg::tor_id_t   i_hop_ocs0,
    input  relay_pkg::tor_id_t   i_hop_ocs1,
    input  logic                 i_grant_valid,
    input  logic                 i_grant_port,
    input  relay_pkg::size_vec_t i_grant_offer,
    input  relay_pkg::size_t     i_grant_cap,
    output logic [1:0]           o_relay_valid,
    output relay_pkg::size_vec_t o_relay,
    output logic                 o_alloc_done
);

    import relay_pkg::*;

    size_t     avail [`RELAY_QUEUE_NUM];
    tor_id_t   prim;
    tor_id_t   sec;
    size_t     prim_amt;
    size_t     sec_amt;
    size_vec_t relay_d;

    logic      s1_valid;
    logic      s1_port;
    tor_id_t   s1_prim;
    tor_id_t   s1_sec;
    size_t     s1_prim_amt;
    size_t     s1_rem;
    size_t     s1_sec_offer;

    function automatic size_t min3(input size_t a, input size_t b, input size_t c);
        size_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stage 1 primary neighbour
    ////////////////////////////////////////////////////////////////////////////

    // port 0 faces ocs0, port 1 faces ocs1
    assign prim     = i_grant_port ? i_hop_ocs1 : i_hop_ocs0;
    assign sec      = i_grant_port ? i_hop_ocs0 : i_hop_ocs1;
    assign prim_amt = min3(i_grant_offer[prim], i_grant_cap, avail[prim]);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            s1_valid <= 1'b0;
            s1_port  <= 1'b0;
        end else begin
            s1_valid <= i_grant_valid;
            if (i_grant_valid) begin
                s1_port <= i_grant_port;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_grant_valid) begin
            s1_prim      <= prim;
            s1_sec       <= sec;
            s1_prim_amt  <= prim_amt;
            s1_rem       <= i_grant_cap - prim_amt;
            s1_sec_offer <= i_grant_offer[sec];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 2 secondary neighbour and result
    ////////////////////////////////////////////////////////////////////////////

    assign sec_amt = min3(s1_sec_offer, s1_rem, avail[s1_sec]);

    always_comb begin
        relay_d          = '0;
        relay_d[s1_prim] = s1_prim_amt;
        relay_d[s1_sec]  = sec_amt;
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_relay_valid <= '0;
            o_relay       <= '0;
            o_alloc_done  <= 1'b0;
        end else begin
            o_relay_valid <= {s1_valid & s1_port, s1_valid & ~s1_port};
            o_alloc_done  <= s1_valid;
            if (s1_valid) begin
                o_relay <= relay_d;
            end
        end
    end

    // spare buffer per queue charged with every result
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            for (int q = 0; q < `RELAY_QUEUE_NUM; q++) begin
                avail[q] <= '0;
            end
        end else if (i_snap_valid) begin
            for (int q = 0; q < `RELAY_QUEUE_NUM; q++) begin
                avail[q] <= size_t'(`RELAY_SLOT_MAX_BYTES) - i_snap_local[q] - i_snap_unlocal[q];
            end
        end else if (s1_valid) begin
            for (int q = 0; q < `RELAY_QUEUE_NUM; q++) begin
                avail[q] <= avail[q] - relay_d[q];
            end
        end
    end

endmodule

/* hw/relay_sched_top.sv */
`timescale 1ns/1ns

module relay_sched_top #(
    parameter relay_pkg::tor_id_t my_tor_id = '0
) (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_slot_start,
    input  relay_pkg::slot_id_t  i_slot_id,
    output logic                 o_queue_req,
    input  logic                 i_queue_ack,
    input  relay_pkg::size_vec_t i_local_size,
    input  relay_pkg::size_vec_t i_unlocal_size,
    input  logic                 i_offer_valid_0,
    input  relay_pkg::size_vec_t i_offer_0,
    input  relay_pkg::size_t     i_offer_cap_0,
    input  logic                 i_offer_valid_1,
    input  relay_pkg::size_vec_t i_offer_1,
    input  relay_pkg::size_t     i_offer_cap_1,
    output logic [1:0]           o_relay_valid,
    output relay_pkg::size_vec_t o_relay
);

    import relay_pkg::*;

    logic      snap_valid;
    slot_id_t  snap_slot_id;
    size_vec_t snap_local;
    size_vec_t snap_unlocal;

    tor_id_t   hop_ocs0;
    tor_id_t   hop_ocs1;

    logic      grant_valid;
    logic      grant_port;
    size_vec_t grant_offer;
    size_t     grant_cap;
    logic      alloc_done;

    slot_snapshot u_snapshot (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_slot_start   (i_slot_start),
        .i_slot_id      (i_slot_id),
        .i_queue_ack    (i_queue_ack),
        .i_local_size   (i_local_size),
        .i_unlocal_size (i_unlocal_size),
        .o_queue_req    (o_queue_req),
        .o_snap_valid   (snap_valid),
        .o_snap_slot_id (snap_slot_id),
        .o_snap_local   (snap_local),
        .o_snap_unlocal (snap_unlocal)
    );

    next_hop_lookup #(
        .my_tor_id (my_tor_id)
    ) u_hop (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_snap_valid   (snap_valid),
        .i_snap_slot_id (snap_slot_id),
        .o_hop_valid    (),
        .o_hop_ocs0     (hop_ocs0),
        .o_hop_ocs1     (hop_ocs1)
    );

    offer_arbiter u_arb (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_offer_valid_0 (i_offer_valid_0),
        .i_offer_valid_1 (i_offer_valid_1),
        .i_offer_0       (i_offer_0),
        .i_offer_1       (i_offer_1),
        .i_offer_cap_0   (i_offer_cap_0),
        .i_offer_cap_1   (i_offer_cap_1),
        .i_alloc_done    (alloc_done),
        .o_grant_valid   (grant_valid),
        .o_grant_port    (grant_port),
        .o_grant_offer   (grant_offer),
        .o_grant_cap     (grant_cap)
    );

    relay_allocator u_alloc (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_snap_valid   (snap_valid),
        .i_snap_local   (snap_local),
        .i_snap_unlocal (snap_unlocal),
        .i_hop_ocs0     (hop_ocs0),
        .i_hop_ocs1     (hop_ocs1),
        .i_grant_valid  (grant_valid),
        .i_grant_port   (grant_port),
        .i_grant_offer  (grant_offer),
        .i_grant_cap    (grant_cap),
        .o_relay_valid  (o_relay_valid),
        .o_relay        (o_relay),
        .o_alloc_done   (alloc_done)
    );

endmodule

/* dv/relay_sched_tb.sv */
`timescale 1ns/1ns

`include "relay_macros.svh"

module relay_sched_tb;

    import relay_pkg::*;

    localparam int clk_period      = 20;
    localparam int num_tests       = 6;
    localparam int offers_per_test = 32;
    localparam int my_tor          = 0;
    localparam int budget          = `RELAY_SLOT_MAX_BYTES;

    logic       i_clk;
    logic       i_rst;
    logic       i_slot_start;
    slot_id_t   i_slot_id;
    logic       o_queue_req;
    logic       i_queue_ack;
    size_vec_t  i_local_size;
    size_vec_t  i_unlocal_size;
    logic       i_offer_valid_0;
    logic       i_offer_valid_1;
    size_vec_t  i_offer_0;
    size_vec_t  i_offer_1;
    size_t      i_offer_cap_0;
    size_t      i_offer_cap_1;
    logic [1:0] o_relay_valid;
    size_vec_t  o_relay;

    // reference model state
    size_t      m_avail [`RELAY_QUEUE_NUM];
    int         m_h0;
    int         m_h1;
    slot_id_t   cur_slot;
    logic       small_mode;
    size_vec_t  exp_vec0 [$];
    size_vec_t  exp_vec1 [$];
    int         exp_port [$];
    int         err_count;
    int         err_base;
    int         tests_failed;
    logic       req_prev = 1'b0;

    relay_sched_top u_dut (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_slot_start    (i_slot_start),
        .i_slot_id       (i_slot_id),
        .o_queue_req     (o_queue_req),
        .i_queue_ack     (i_queue_ack),
        .i_local_size    (i_local_size),
        .i_unlocal_size  (i_unlocal_size),
        .i_offer_valid_0 (i_offer_valid_0),
        .i_offer_0       (i_offer_0),
        .i_offer_cap_0   (i_offer_cap_0),
        .i_offer_valid_1 (i_offer_valid_1),
        .i_offer_1       (i_offer_1),
        .i_offer_cap_1   (i_offer_cap_1),
        .o_relay_valid   (o_relay_valid),
        .o_relay         (o_relay)
    );

    initial begin
        i_clk = 1'b0;
        forever #(clk_period / 2) i_clk = ~i_clk;
    end

    initial begin : watchdog
        #(num_tests * offers_per_test * 40 * clk_period);
        $display("timeout: run did not finish in %0d cycles", num_tests * offers_per_test * 40);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks and model
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        err_count++;
        $display("%0t failure: %s", $time, msg);
    endtask

    function automatic size_t smaller(input size_t a, input size_t b);
        return (a < b) ? a : b;
    endfunction

    function automatic size_vec_t rand_vec(input int unsigned max_val);
        size_vec_t v;
        for (int q = 0; q < `RELAY_QUEUE_NUM; q++) begin
            v[q] = $urandom_range(max_val, 0);
        end
        return v;
    endfunction

    // primary neighbour first, whatever cap is left goes to the secondary
    task automatic predict_relay(input int port, input size_vec_t offer, input size_t cap);
        int        prim;
        int        sec;
        size_vec_t res;
        res       = '0;
        prim      = (port == 0) ? m_h0 : m_h1;
        sec       = (port == 0) ? m_h1 : m_h0;
        res[prim] = smaller(smaller(offer[prim], cap), m_avail[prim]);
        res[sec]  = smaller(smaller(offer[sec], cap - res[prim]), m_avail[sec]);
        for (int q = 0; q < `RELAY_QUEUE_NUM; q++) begin
            m_avail[q] = m_avail[q] - res[q];
        end
        exp_port.push_back(port);
        if (port == 0) begin
            exp_vec0.push_back(res);
        end else begin
            exp_vec1.push_back(res);
        end
    endtask

    task automatic check_relay();
        int        p;
        size_vec_t exp;
        if (exp_port.size() == 0) begin
            report_failure("relay result with no offer outstanding");
        end else begin
            p   = exp_port.pop_front();
            exp = (p == 0) ? exp_vec0.pop_front() : exp_vec1.pop_front();
            check_value("o_relay_valid", o_relay_valid, 2'b01 << p);
            check_value("o_relay", o_relay, exp);
        end
    endtask

    always @(posedge i_clk) begin
        if (!i_rst && o_relay_valid != 2'b00) begin
            check_relay();
        end
    end

    // request must not rise under an old ack, nor fall without one
    always @(posedge i_clk) begin
        if (!i_rst && o_queue_req && !req_prev && i_queue_ack) begin
            report_failure("o_queue_req rose while the ack was still high");
        end
        if (!i_rst && !o_queue_req && req_prev && !i_queue_ack) begin
            report_failure("o_queue_req fell without an ack");
        end
        req_prev <= o_queue_req;
    end

    ////////////////////////////////////////////////////////////////////////////
    // queue manager
    ////////////////////////////////////////////////////////////////////////////

    initial begin : queue_responder
        int          delay;
        int          lat;
        int          hold;
        int          nxt;
        int unsigned spare;
        int unsigned loc;
        size_vec_t   local_v;
        size_vec_t   unlocal_v;
        forever begin
            do @(posedge i_clk); while (!o_queue_req);
            delay = $urandom_range(5, 0);
            repeat (delay) @(posedge i_clk);
            for (int q = 0; q < `RELAY_QUEUE_NUM; q++) begin
                spare        = small_mode ? $urandom_range(1023, 0) : $urandom_range(budget, 0);
                loc          = $urandom_range(budget - spare, 0);
                local_v[q]   = loc;
                unlocal_v[q] = budget - spare - loc;
                m_avail[q]   = budget - local_v[q] - unlocal_v[q];
            end
            nxt  = (int'(cur_slot) + 1) % `RELAY_SLOT_NUM;
            m_h0 = (my_tor + 1 + 2 * nxt) % `RELAY_TOR_NUM;
            m_h1 = ((my_tor - 1 - 2 * nxt) % `RELAY_TOR_NUM + `RELAY_TOR_NUM) % `RELAY_TOR_NUM;
            i_local_size   <= local_v;
            i_unlocal_size <= unlocal_v;
            i_queue_ack    <= 1'b1;
            lat = 0;
            do begin
                @(posedge i_clk);
                lat++;
            end while (o_queue_req);
            if (lat > 4) begin
                report_failure("o_queue_req stayed high too long after the ack");
            end
            // ack may linger past the next slot start
            hold = $urandom_range(10, 0);
            repeat (hold) @(posedge i_clk);
            i_queue_ack    <= 1'b0;
            // junk once the ack is gone
            i_local_size   <= rand_vec(32'hffff_ffff);
            i_unlocal_size <= rand_vec(32'hffff_ffff);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic take_snapshot(input slot_id_t slot, input logic low_spare);
        int cycles;
        small_mode = low_spare;
        cur_slot   = slot;
        @(posedge i_clk);
        check_value("o_queue_req", o_queue_req, 1'b0);
        i_slot_start <= 1'b1;
        i_slot_id    <= slot;
        @(posedge i_clk);
        i_slot_start <= 1'b0;
        cycles = 0;
        while (!o_queue_req && cycles < 16) begin
            @(posedge i_clk);
            cycles++;
        end
        if (!o_queue_req) begin
            report_failure("o_queue_req did not rise after the slot start");
        end
        cycles = 0;
        while (o_queue_req && cycles < 20) begin
            @(posedge i_clk);
            cycles++;
        end
        if (o_queue_req) begin
            report_failure("o_queue_req did not fall after the ack");
        end
        repeat (4) @(posedge i_clk);
    endtask

    task automatic send_offers(input logic [1:0] mask, input size_vec_t o0, input size_t c0,
                               input size_vec_t o1, input size_t c1);
        int cycles;
        if (mask[0]) predict_relay(0, o0, c0);
        if (mask[1]) predict_relay(1, o1, c1);
        @(posedge i_clk);
        i_offer_valid_0 <= mask[0];
        i_offer_0       <= o0;
        i_offer_cap_0   <= c0;
        i_offer_valid_1 <= mask[1];
        i_offer_1       <= o1;
        i_offer_cap_1   <= c1;
        @(posedge i_clk);
        i_offer_valid_0 <= 1'b0;
        i_offer_valid_1 <= 1'b0;
        cycles = 0;
        while (exp_port.size() != 0 && cycles < 40) begin
            @(posedge i_clk);
            cycles++;
        end
        if (exp_port.size() != 0) begin
            report_failure("relay result missing after 40 cycles");
            exp_port.delete();
            exp_vec0.delete();
            exp_vec1.delete();
        end
    endtask

    task automatic end_test(input int num, input string name);
        if (err_count == err_base) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name, err_count - err_base);
        end
        err_base = err_count;
    endtask

    initial begin : main
        size_vec_t  full;
        logic [1:0] mask;
        void'($urandom(32'hde43_2a88));
        err_count       = 0;
        err_base        = 0;
        tests_failed    = 0;
        small_mode      = 1'b0;
        cur_slot        = '0;
        full            = '1;
        i_rst           = 1'b1;
        i_slot_start    = 1'b0;
        i_slot_id       = '0;
        i_queue_ack     = 1'b0;
        i_local_size    = '0;
        i_unlocal_size  = '0;
        i_offer_valid_0 = 1'b0;
        i_offer_valid_1 = 1'b0;
        i_offer_0       = '0;
        i_offer_1       = '0;
        i_offer_cap_0   = '0;
        i_offer_cap_1   = '0;
        repeat (4) @(posedge i_clk);
        i_rst <= 1'b0;

        repeat (10) begin
            @(posedge i_clk);
            check_value("o_queue_req", o_queue_req, 1'b0);
            check_value("o_relay_valid", o_relay_valid, 2'b00);
            check_value("o_relay", o_relay, '0);
        end
        end_test(1, "reset state");

        repeat (6) take_snapshot($urandom_range(1, 0), 1'b0);
        end_test(2, "queue handshake");

        for (int s = 0; s < 2; s++) begin
            take_snapshot(s, 1'b0);
            send_offers(2'b01, rand_vec(32'h7ffff), $urandom_range(32'hfffff, 0), '0, '0);
        end
        end_test(3, "port 0 offer");

        for (int s = 0; s < 2; s++) begin
            take_snapshot(s, 1'b0);
            send_offers(2'b10, '0, '0, rand_vec(32'h7ffff), $urandom_range(32'hfffff, 0));
        end
        end_test(4, "port 1 offer");

        // small spare space so the stream runs dry
        take_snapshot($urandom_range(1, 0), 1'b1);
        for (int i = 0; i < offers_per_test; i++) begin
            mask = $urandom_range(3, 1);
            send_offers(mask, rand_vec(511), $urandom_range(767, 0),
                        rand_vec(511), $urandom_range(767, 0));
        end
        send_offers(2'b11, full, '1, full, '1);
        send_offers(2'b11, full, '1, full, '1);
        end_test(5, "offer stream");

        take_snapshot($urandom_range(1, 0), 1'b0);
        send_offers(2'b10, '0, '0, rand_vec(32'h7ffff), $urandom_range(32'hfffff, 0));
        send_offers(2'b01, rand_vec(32'h7ffff), $urandom_range(32'hfffff, 0), '0, '0);
        end_test(6, "avail reload");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 num_tests, num_tests - tests_failed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
hw/relay_pkg.sv
hw/slot_snapshot.sv
hw/next_hop_lookup.sv
hw/offer_arbiter.sv
hw/relay_allocator.sv
hw/relay_sched_top.sv
dv/relay_sched_tb.sv
